/* rtl/memory_game_settings.svh */
// Round counts, move timeout lengths and show phase timing for the memory game
`ifndef MEMORY_GAME_SETTINGS_SVH
`define MEMORY_GAME_SETTINGS_SVH

// Rounds per game, selected by the round level
`define MG_ROUNDS_SHORT 8
`define MG_ROUNDS_LONG 16

// Move timeout in clock cycles, selected by the time level
`define MG_TIMEOUT_SHORT 64
`define MG_TIMEOUT_LONG 128

// Show phase: cycles an entry is lit, then dark cycles before the next one
`define MG_SHOW_CYCLES 8
`define MG_GAP_CYCLES 4

`endif

/* rtl/memory_game_pkg.sv */
// Package with the controller state type, the move type and the default sequence
`default_nettype none

package memory_game_pkg;

    // One bit per button or LED
    typedef logic [3:0] move_t;

    typedef enum logic [4:0] {
        st_idle   = 5'd0,
        st_load   = 5'd1,
        st_show   = 5'd2,
        st_wait   = 5'd3,
        st_check  = 5'd4,
        st_next   = 5'd5,
        st_record = 5'd6,
        st_paused = 5'd7,
        st_won    = 5'd8,
        st_lost   = 5'd9
    } game_state_t;

    // Sequence memory contents after reset or a new start
    localparam move_t default_sequence [16] = '{
        4'b0001,
        4'b0010,
        4'b0100,
        4'b1000,
        4'b0100,
        4'b0001,
        4'b1000,
        4'b0010,
        4'b0001,
        4'b0100,
        4'b0010,
        4'b1000,
        4'b1000,
        4'b0001,
        4'b0100,
        4'b0010
    };

endpackage

`default_nettype wire

/* rtl/game_ctrl_if.sv */
// Interface bundling control strobes and condition flags between controller and datapath
`timescale 1ns/1ps
`default_nettype none

interface game_ctrl_if;

    // Strobes from the control unit
    logic clear_all;
    logic load_config;
    logic clear_round;
    logic count_round;
    logic clear_move;
    logic count_move;
    logic clear_timer;
    logic count_timer;
    logic show_memory;
    logic show_player;
    logic write_memory;

    // Conditions from the datapath
    logic move_done;
    logic move_correct;
    logic move_is_last;
    logic round_is_last;
    logic timer_done;
    logic show_done;

    modport control (
        output clear_all, load_config, clear_round, count_round, clear_move, count_move,
               clear_timer, count_timer, show_memory, show_player, write_memory,
        input  move_done, move_correct, move_is_last, round_is_last, timer_done, show_done
    );

    modport datapath (
        input  clear_all, load_config, clear_round, count_round, clear_move, count_move,
               clear_timer, count_timer, show_memory, show_player, write_memory,
        output move_done, move_correct, move_is_last, round_is_last, timer_done, show_done
    );

endinterface

`default_nettype wire

/* rtl/hex7seg.sv */
// Hex digit to active-low seven-segment decoder
`timescale 1ns/1ps
`default_nettype none

module hex7seg (
    input  wire logic [3:0] hexa,
    output logic      [6:0] display
);

    // Segment order is g f e d c b a, a lit segment is 0
    always_comb begin
        case (hexa)
            4'h0: display = 7'b1000000;
            4'h1: display = 7'b1111001;
            4'h2: display = 7'b0100100;
            4'h3: display = 7'b0110000;
            4'h4: display = 7'b0011001;
            4'h5: display = 7'b0010010;
            4'h6: display = 7'b0000010;
            4'h7: display = 7'b1111000;
            4'h8: display = 7'b0000000;
            4'h9: display = 7'b0010000;
            4'ha: display = 7'b0001000;
            4'hb: display = 7'b0000011;
            4'hc: display = 7'b1000110;
            4'hd: display = 7'b0100001;
            4'he: display = 7'b0000110;
            default: display = 7'b0001110;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/game_datapath.sv */
// Game datapath with settings, counters, timers, sequence memory and button capture
`include "memory_game_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module game_datapath (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic            [3:0] buttons,
    input  wire logic                  round_level,
    input  wire logic                  time_level,
    input  wire logic                  record_mode,
    game_ctrl_if.datapath              ctrl,
    output memory_game_pkg::move_t     leds,
    output logic                 [3:0] round_number,
    output logic                       record_active
);

    localparam int timer_w = $clog2(`MG_TIMEOUT_LONG);
    localparam int show_w  = $clog2(`MG_SHOW_CYCLES + `MG_GAP_CYCLES);

    localparam logic [timer_w-1:0] timeout_short_last = timer_w'(`MG_TIMEOUT_SHORT - 1);
    localparam logic [timer_w-1:0] timeout_long_last  = timer_w'(`MG_TIMEOUT_LONG - 1);
    localparam logic [show_w-1:0]  lit_cycles         = show_w'(`MG_SHOW_CYCLES);
    localparam logic [show_w-1:0]  entry_last         =
        show_w'(`MG_SHOW_CYCLES + `MG_GAP_CYCLES - 1);
    localparam logic [3:0] round_short_last = 4'(`MG_ROUNDS_SHORT - 1);
    localparam logic [3:0] round_long_last  = 4'(`MG_ROUNDS_LONG - 1);

    logic round_level_reg;
    logic time_level_reg;
    logic [3:0] round_cnt;
    logic [3:0] move_cnt;
    logic [timer_w-1:0] timer_cnt;
    logic [show_w-1:0] show_cnt;
    logic entry_end;
    memory_game_pkg::move_t seq_mem [16];
    memory_game_pkg::move_t btn_reg;
    memory_game_pkg::move_t btn_prev;
    memory_game_pkg::move_t move_reg;

    // Settings sampled while the controller waits for start
    always_ff @(posedge clock) begin
        if (reset) begin
            round_level_reg <= 1'b0;
            time_level_reg  <= 1'b0;
            record_active   <= 1'b0;
        end else if (ctrl.load_config) begin
            round_level_reg <= round_level;
            time_level_reg  <= time_level;
            record_active   <= record_mode;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || ctrl.clear_round) begin
            round_cnt <= 4'd0;
        end else if (ctrl.count_round) begin
            round_cnt <= round_cnt + 4'd1;
        end
    end

    // Move address, also walked through the entries during the show phase
    always_ff @(posedge clock) begin
        if (reset || ctrl.clear_move) begin
            move_cnt <= 4'd0;
        end else if (ctrl.count_move) begin
            move_cnt <= move_cnt + 4'd1;
        end else if (ctrl.show_memory && entry_end) begin
            move_cnt <= ctrl.move_is_last ? 4'd0 : move_cnt + 4'd1;
        end
    end

    // Lit and gap phases of one shown entry
    always_ff @(posedge clock) begin
        if (reset || ctrl.clear_move) begin
            show_cnt <= '0;
        end else if (ctrl.show_memory) begin
            show_cnt <= entry_end ? '0 : show_cnt + 1'b1;
        end
    end

    // Saturates at the limit so timer_done holds
    always_ff @(posedge clock) begin
        if (reset || ctrl.clear_timer) begin
            timer_cnt <= '0;
        end else if (ctrl.count_timer && !ctrl.timer_done) begin
            timer_cnt <= timer_cnt + 1'b1;
        end
    end

    // Restored to the default sequence on reset and on each new game
    always_ff @(posedge clock) begin
        if (reset || ctrl.clear_all) begin
            seq_mem <= memory_game_pkg::default_sequence;
        end else if (ctrl.write_memory) begin
            seq_mem[round_cnt + 4'd1] <= move_reg;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            btn_reg  <= '0;
            btn_prev <= '0;
        end else begin
            btn_reg  <= buttons;
            btn_prev <= btn_reg;
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.move_done) begin
            move_reg <= btn_reg;
        end
    end

    assign entry_end          = (show_cnt == entry_last);
    assign ctrl.move_done     = (btn_reg != '0) && (btn_prev == '0);
    assign ctrl.move_correct  = (move_reg == seq_mem[move_cnt]);
    assign ctrl.move_is_last  = (move_cnt == round_cnt);
    assign ctrl.round_is_last = (round_cnt == (round_level_reg ? round_long_last
                                                               : round_short_last));
    assign ctrl.timer_done    = (timer_cnt == (time_level_reg ? timeout_long_last
                                                              : timeout_short_last));
    assign ctrl.show_done     = entry_end && ctrl.move_is_last;

    always_comb begin
        if (ctrl.show_memory) begin
            leds = (show_cnt < lit_cycles) ? seq_mem[move_cnt] : '0;
        end else if (ctrl.show_player) begin
            leds = btn_reg;
        end else begin
            leds = '0;
        end
    end

    assign round_number = round_cnt;

    // Recording and showing are separate phases of a round
    a_no_write_during_show: assert property (
        @(posedge clock) disable iff (reset) !(ctrl.write_memory && ctrl.show_memory)
    );

    // Rounds only advance below the last round
    a_round_in_range: assert property (
        @(posedge clock) disable iff (reset) ctrl.count_round |-> !ctrl.round_is_last
    );

endmodule

`default_nettype wire

/* rtl/game_control.sv */
// Game control FSM for show, player turn, record, pause and end states
`timescale 1ns/1ps
`default_nettype none

module game_control (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  start,
    input  wire logic                  pause,
    input  wire logic                  record_active,
    game_ctrl_if.control               ctrl,
    output logic                       won,
    output logic                       lost,
    output logic                       ready,
    output logic                       player_turn,
    output logic                       new_move,
    output logic                       paused,
    output memory_game_pkg::game_state_t state,
    output logic                       timeout
);

    memory_game_pkg::game_state_t next_state;
    memory_game_pkg::game_state_t return_state;
    logic timeout_hit;

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= memory_game_pkg::st_idle;
            return_state <= memory_game_pkg::st_idle;
        end else begin
            state <= next_state;
            if (next_state == memory_game_pkg::st_paused &&
                state != memory_game_pkg::st_paused) begin
                return_state <= state;
            end
        end
    end

    // Tells a timeout loss apart from a wrong move
    always_ff @(posedge clock) begin
        if (reset || ctrl.clear_all) begin
            timeout <= 1'b0;
        end else if (timeout_hit) begin
            timeout <= 1'b1;
        end
    end

    always_comb begin
        next_state        = state;
        timeout_hit       = 1'b0;
        ctrl.clear_all    = 1'b0;
        ctrl.load_config  = 1'b0;
        ctrl.clear_round  = 1'b0;
        ctrl.count_round  = 1'b0;
        ctrl.clear_move   = 1'b0;
        ctrl.count_move   = 1'b0;
        ctrl.clear_timer  = 1'b0;
        ctrl.count_timer  = 1'b0;
        ctrl.show_memory  = 1'b0;
        ctrl.show_player  = 1'b0;
        ctrl.write_memory = 1'b0;
        case (state)
            memory_game_pkg::st_idle,
            memory_game_pkg::st_won,
            memory_game_pkg::st_lost: begin
                // Settings track the inputs until the start edge
                ctrl.load_config = 1'b1;
                if (start) begin
                    next_state = memory_game_pkg::st_load;
                end
            end
            memory_game_pkg::st_load: begin
                ctrl.clear_all   = 1'b1;
                ctrl.clear_round = 1'b1;
                ctrl.clear_move  = 1'b1;
                ctrl.clear_timer = 1'b1;
                next_state       = memory_game_pkg::st_show;
            end
            memory_game_pkg::st_show: begin
                ctrl.show_memory = 1'b1;
                ctrl.clear_timer = 1'b1;
                if (pause) begin
                    next_state = memory_game_pkg::st_paused;
                end else if (ctrl.show_done) begin
                    next_state = memory_game_pkg::st_wait;
                end
            end
            memory_game_pkg::st_wait: begin
                ctrl.show_player = 1'b1;
                ctrl.count_timer = 1'b1;
                if (pause) begin
                    next_state = memory_game_pkg::st_paused;
                end else if (ctrl.move_done) begin
                    next_state = memory_game_pkg::st_check;
                end else if (ctrl.timer_done) begin
                    timeout_hit = 1'b1;
                    next_state  = memory_game_pkg::st_lost;
                end
            end
            memory_game_pkg::st_check: begin
                ctrl.count_move  = 1'b1;
                ctrl.clear_timer = 1'b1;
                if (!ctrl.move_correct) begin
                    next_state = memory_game_pkg::st_lost;
                end else if (!ctrl.move_is_last) begin
                    next_state = memory_game_pkg::st_wait;
                end else if (ctrl.round_is_last) begin
                    next_state = memory_game_pkg::st_won;
                end else if (record_active) begin
                    next_state = memory_game_pkg::st_record;
                end else begin
                    next_state = memory_game_pkg::st_next;
                end
            end
            memory_game_pkg::st_record: begin
                ctrl.show_player = 1'b1;
                if (pause) begin
                    next_state = memory_game_pkg::st_paused;
                end else if (ctrl.move_done) begin
                    next_state = memory_game_pkg::st_next;
                end
            end
            memory_game_pkg::st_next: begin
                // Only reached through record in record mode
                ctrl.write_memory = record_active;
                ctrl.count_round  = 1'b1;
                ctrl.clear_move   = 1'b1;
                ctrl.clear_timer  = 1'b1;
                next_state        = memory_game_pkg::st_show;
            end
            memory_game_pkg::st_paused: begin
                if (!pause) begin
                    next_state = return_state;
                end
            end
            default: begin
                next_state = memory_game_pkg::st_idle;
            end
        endcase
    end

    assign won         = (state == memory_game_pkg::st_won);
    assign lost        = (state == memory_game_pkg::st_lost);
    assign ready       = (state == memory_game_pkg::st_idle) || won || lost;
    assign player_turn = (state == memory_game_pkg::st_wait);
    assign new_move    = (state == memory_game_pkg::st_record);
    assign paused      = (state == memory_game_pkg::st_paused);

    // A win leaves the datapath on its last round
    a_win_on_last_round: assert property (
        @(posedge clock) disable iff (reset) $rose(won) |-> ctrl.round_is_last
    );

    // Every checked move restarts the move timeout
    a_check_clears_timer: assert property (
        @(posedge clock) disable iff (reset)
            (state == memory_game_pkg::st_check) |=> !ctrl.timer_done
    );

endmodule

`default_nettype wire

/* rtl/memory_game.sv */
// Memory game top level with datapath, control unit and debug display decoders
`timescale 1ns/1ps
`default_nettype none

module memory_game (
    input  wire logic       clock,
    input  wire logic       reset,
    input  wire logic       start,
    input  wire logic [3:0] buttons,
    input  wire logic       round_level,
    input  wire logic       time_level,
    input  wire logic       record_mode,
    input  wire logic       pause,
    output logic            won,
    output logic            lost,
    output logic            ready,
    output logic            player_turn,
    output logic            new_move,
    output logic      [3:0] leds,
    output logic            paused,
    output logic      [6:0] db_round,
    output logic      [6:0] db_state,
    output logic            db_timeout
);

    game_ctrl_if ctrl_bus ();

    memory_game_pkg::game_state_t state;
    logic [3:0] round_number;
    logic       record_active;

    game_datapath datapath (
        .clock         ( clock         ),
        .reset         ( reset         ),
        .buttons       ( buttons       ),
        .round_level   ( round_level   ),
        .time_level    ( time_level    ),
        .record_mode   ( record_mode   ),
        .ctrl          ( ctrl_bus      ),
        .leds          ( leds          ),
        .round_number  ( round_number  ),
        .record_active ( record_active )
    );

    game_control control (
        .clock         ( clock         ),
        .reset         ( reset         ),
        .start         ( start         ),
        .pause         ( pause         ),
        .record_active ( record_active ),
        .ctrl          ( ctrl_bus      ),
        .won           ( won           ),
        .lost          ( lost          ),
        .ready         ( ready         ),
        .player_turn   ( player_turn   ),
        .new_move      ( new_move      ),
        .paused        ( paused        ),
        .state         ( state         ),
        .timeout       ( db_timeout    )
    );

    // Round counter display
    hex7seg display_round (
        .hexa    ( round_number ),
        .display ( db_round     )
    );

    // Low four state bits cover all ten states
    hex7seg display_state (
        .hexa    ( state[3:0] ),
        .display ( db_state   )
    );

endmodule

`default_nettype wire

/* testbench/memory_game_tb.sv */
// Testbench for the memory game top level with LFSR stimulus and assertion checks
`include "memory_game_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module memory_game_tb;

    localparam int wait_limit = 400;
    localparam int sig_turn = 0;
    localparam int sig_new_move = 1;
    localparam int sig_lost = 2;

    logic clock;
    logic reset;
    logic start;
    logic [3:0] buttons;
    logic round_level;
    logic time_level;
    logic record_mode;
    logic pause;
    logic won;
    logic lost;
    logic ready;
    logic player_turn;
    logic new_move;
    logic [3:0] leds;
    logic paused;
    logic [6:0] db_round;
    logic [6:0] db_state;
    logic db_timeout;

    int check_count;
    int error_count;
    int timeout_count;
    int end_delay;
    logic [31:0] lfsr_state;
    memory_game_pkg::move_t expected_seq [16];
    memory_game_pkg::move_t shown [$];
    memory_game_pkg::move_t prev_leds;

    memory_game DUT (
        .clock       ( clock       ),
        .reset       ( reset       ),
        .start       ( start       ),
        .buttons     ( buttons     ),
        .round_level ( round_level ),
        .time_level  ( time_level  ),
        .record_mode ( record_mode ),
        .pause       ( pause       ),
        .won         ( won         ),
        .lost        ( lost        ),
        .ready       ( ready       ),
        .player_turn ( player_turn ),
        .new_move    ( new_move    ),
        .leds        ( leds        ),
        .paused      ( paused      ),
        .db_round    ( db_round    ),
        .db_state    ( db_state    ),
        .db_timeout  ( db_timeout  )
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Collects the lit entries of the current show phase
    always @(negedge clock) begin
        if (reset || ready || player_turn || new_move) begin
            shown.delete();
        end else if (leds != '0 && prev_leds == '0) begin
            shown.push_back(leds);
        end
        prev_leds = leds;
    end

    a_pause_followed: assert property (
        @(posedge clock) disable iff (reset) (player_turn && pause) |=> paused
    ) else begin
        error_count++;
        $display("Error: paused did not follow pause held in a player turn");
    end

    a_end_is_ready: assert property (
        @(posedge clock) disable iff (reset) (won || lost) |-> ready
    ) else begin
        error_count++;
        $display("Error: game ended without ready high");
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    // Active-low seven-segment pattern, segment a in bit 0
    function automatic logic [6:0] segment_pattern(input logic [3:0] digit);
        logic [6:0] lit;
        case (digit)
            4'h0: lit = 7'b0111111;
            4'h1: lit = 7'b0000110;
            4'h2: lit = 7'b1011011;
            4'h3: lit = 7'b1001111;
            4'h4: lit = 7'b1100110;
            4'h5: lit = 7'b1101101;
            4'h6: lit = 7'b1111101;
            4'h7: lit = 7'b0000111;
            4'h8: lit = 7'b1111111;
            4'h9: lit = 7'b1101111;
            4'ha: lit = 7'b1110111;
            4'hb: lit = 7'b1111100;
            4'hc: lit = 7'b0111001;
            4'hd: lit = 7'b1011110;
            4'he: lit = 7'b1111001;
            default: lit = 7'b1110001;
        endcase
        return ~lit;
    endfunction

    function automatic logic signal_value(input int which);
        case (which)
            sig_turn: return player_turn;
            sig_new_move: return new_move;
            default: return lost;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (expected === actual) else begin
            error_count++;
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_range(input string name, input int low, input int high,
                               input int actual);
        check_count++;
        assert (actual >= low && actual <= high) else begin
            error_count++;
            $display("Fail %s: expected %0d to %0d, actual %0d", name, low, high, actual);
        end
    endtask

    task automatic wait_for_signal(input int which, input string what, output int cycles);
        cycles = 0;
        while (!signal_value(which) && cycles < wait_limit) begin
            @(posedge clock);
            #2;
            cycles++;
        end
        if (!signal_value(which)) begin
            timeout_count++;
            $display("Timeout: %s did not rise within %0d cycles", what, wait_limit);
        end
    endtask

    // Notes the first cycle after the press that shows won or lost
    task automatic press_move(input memory_game_pkg::move_t pattern);
        end_delay = -1;
        buttons = pattern;
        for (int i = 1; i <= 6; i++) begin
            if (i == 4) begin
                buttons = '0;
            end
            @(posedge clock);
            #2;
            if ((won || lost) && end_delay < 0) begin
                end_delay = i;
            end
        end
    endtask

    task automatic start_game(input logic rounds, input logic times, input logic record);
        expected_seq = memory_game_pkg::default_sequence;
        round_level = rounds;
        time_level = times;
        record_mode = record;
        start = 1'b1;
        @(posedge clock);
        #2;
        start = 1'b0;
        check_value("ready after start", 0, ready);
        check_value("won after start", 0, won);
        check_value("lost after start", 0, lost);
    endtask

    task automatic await_turn(input int round);
        int cycles;
        wait_for_signal(sig_turn, "player_turn", cycles);
        check_value($sformatf("round %0d show length", round), round, shown.size());
        for (int i = 0; i < round && i < shown.size(); i++) begin
            check_value($sformatf("round %0d show entry %0d", round, i),
                        expected_seq[i], shown[i]);
        end
        // Round counter starts at zero for the first round
        check_value($sformatf("round %0d round display", round),
                    segment_pattern(4'(round - 1)), db_round);
        check_value($sformatf("round %0d state display", round),
                    segment_pattern(4'(memory_game_pkg::st_wait)), db_state);
    endtask

    task automatic play_moves(input int round);
        for (int i = 0; i < round; i++) begin
            press_move(expected_seq[i]);
        end
    endtask

    function automatic memory_game_pkg::move_t wrong_move(input memory_game_pkg::move_t right);
        logic [1:0] index;
        index = 2'(random_bits(2));
        if ((4'b0001 << index) == right) begin
            index = index + 2'd1;
        end
        return 4'b0001 << index;
    endfunction

    initial begin
        int cycles;
        memory_game_pkg::move_t move;
        check_count = 0;
        error_count = 0;
        timeout_count = 0;
        end_delay = -1;
        lfsr_state = 32'h3179;
        prev_leds = '0;
        reset = 1'b1;
        start = 1'b0;
        buttons = '0;
        round_level = 1'b0;
        time_level = 1'b0;
        record_mode = 1'b0;
        pause = 1'b0;
        repeat (2) @(posedge clock);
        #2;
        reset = 1'b0;

        check_value("reset ready", 1, ready);
        check_value("reset won", 0, won);
        check_value("reset lost", 0, lost);
        check_value("reset player_turn", 0, player_turn);
        check_value("reset new_move", 0, new_move);
        check_value("reset paused", 0, paused);
        check_value("reset leds", 0, leds);
        check_value("reset round display", segment_pattern(4'd0), db_round);
        check_value("reset state display",
                    segment_pattern(4'(memory_game_pkg::st_idle)), db_state);

        // Full game of 8 rounds on the default sequence
        start_game(1'b0, 1'b0, 1'b0);
        for (int r = 1; r <= `MG_ROUNDS_SHORT; r++) begin
            await_turn(r);
            play_moves(r);
        end
        check_range("win delay", 1, 4, end_delay);
        check_value("win won", 1, won);
        check_value("win lost", 0, lost);
        check_value("win state display",
                    segment_pattern(4'(memory_game_pkg::st_won)), db_state);

        // Wrong second move in round 2
        start_game(1'b0, 1'b0, 1'b0);
        await_turn(1);
        play_moves(1);
        await_turn(2);
        press_move(expected_seq[0]);
        press_move(wrong_move(expected_seq[1]));
        check_range("wrong move delay", 1, 4, end_delay);
        check_value("wrong move lost", 1, lost);
        check_value("wrong move timeout flag", 0, db_timeout);
        check_value("wrong move ready", 1, ready);
        check_value("lost state display",
                    segment_pattern(4'(memory_game_pkg::st_lost)), db_state);

        // Pause held past the timeout, then a timeout loss in round 2
        start_game(1'b0, 1'b0, 1'b0);
        await_turn(1);
        pause = 1'b1;
        for (int i = 0; i < `MG_TIMEOUT_SHORT + 8; i++) begin
            @(posedge clock);
            #2;
            check_value("paused while held", 1, paused);
            check_value("lost while paused", 0, lost);
        end
        check_value("paused state display",
                    segment_pattern(4'(memory_game_pkg::st_paused)), db_state);
        pause = 1'b0;
        @(posedge clock);
        #2;
        check_value("paused after release", 0, paused);
        check_value("turn after release", 1, player_turn);
        play_moves(1);
        check_value("game goes on after pause", -1, end_delay);
        await_turn(2);
        wait_for_signal(sig_lost, "lost", cycles);
        check_range("timeout delay", `MG_TIMEOUT_SHORT, `MG_TIMEOUT_SHORT + 4, cycles);
        check_value("timeout flag", 1, db_timeout);

        // Record mode builds the sequence from random one-hot moves
        start_game(1'b0, 1'b0, 1'b1);
        for (int r = 1; r <= `MG_ROUNDS_SHORT; r++) begin
            await_turn(r);
            if (r > 1 && shown.size() > 0) begin
                check_value("recorded move shown last", expected_seq[r - 1], shown[$]);
            end
            play_moves(r);
            if (r < `MG_ROUNDS_SHORT) begin
                wait_for_signal(sig_new_move, "new_move", cycles);
                move = 4'b0001 << random_bits(2);
                press_move(move);
                expected_seq[r] = move;
            end
        end
        check_value("record game won", 1, won);
        check_value("record game lost", 0, lost);

        $display("Checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
rtl/memory_game_pkg.sv
rtl/game_ctrl_if.sv
rtl/hex7seg.sv
rtl/game_datapath.sv
rtl/game_control.sv
rtl/memory_game.sv
testbench/memory_game_tb.sv
